//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_rv_wb_cpu -Mdir obj_dir
	./obj_dir/Vtb_rv_wb_cpu | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
common/rv_pkg.sv
common/bus_pkg.sv
core/rv_decoder.sv
core/rv_alu.sv
core/rv_regfile.sv
core/rv_sequencer.sv
bus/wb_master.sv
src/rv_wb_cpu.sv
testbench/rv_wb_cpu_chk.sv
testbench/tb_rv_wb_cpu.sv

//--- bus/wb_master.sv
/*
 * Wishbone classic bus master
 * runs one read or write cycle per core request and hands back
 * a one-cycle done with the read data
 */
`timescale 1ns/1ps

module wb_master import bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  logic                req_we_i,
    input  logic [WB_ADR_W-1:0] req_adr_i,
    input  logic [WB_DAT_W-1:0] req_wdat_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    input  logic                wb_ack_i,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_we_o,
    output logic                wb_stb_o,
    output logic                wb_cyc_o,
    output logic                done_o,
    output logic [WB_DAT_W-1:0] rdata_o
);

    wb_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= W_IDLE;
            wb_adr_o <= '0;
            wb_dat_o <= '0;
            wb_we_o  <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_cyc_o <= 1'b0;
            done_o   <= 1'b0;
            rdata_o  <= '0;
        end else begin
            done_o <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (req_i) begin
                        wb_adr_o <= req_adr_i;
                        wb_dat_o <= req_we_i ? req_wdat_i : '0;
                        wb_we_o  <= req_we_i;
                        wb_stb_o <= 1'b1;
                        wb_cyc_o <= 1'b1;
                        state    <= req_we_i ? W_WRITE : W_READ;
                    end
                end
                W_READ, W_WRITE: begin
                    // outputs hold until the slave acks
                    if (wb_ack_i) begin
                        if (state == W_READ) begin
                            rdata_o <= wb_dat_i;
                        end
                        wb_adr_o <= '0;
                        wb_dat_o <= '0;
                        wb_we_o  <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_cyc_o <= 1'b0;
                        done_o   <= 1'b1;
                        state    <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

//--- common/bus_pkg.sv
/*
 * Wishbone master definitions
 * bus widths and the bus-master state encoding
 */
package bus_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // one classic cycle at a time, direction held in the state
    typedef enum logic [1:0] {
        W_IDLE,
        W_READ,
        W_WRITE
    } wb_state_e;

endpackage

//--- common/rv_pkg.sv
/*
 * RV32I subset ISA definitions
 * word and register-index widths, reset PC, major opcodes,
 * funct3 codes and the ALU operation set
 */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h3300_0000;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // BRANCH funct3 where BLT and BGE compare unsigned
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        PASS_B,
        EQ,
        NE,
        LTU,
        GEU
    } alu_op_e;

endpackage

//--- core/rv_alu.sv
/*
 * ALU
 * add/sub, logic, shifts, LUI pass-through and branch comparisons
 */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o
);

    logic [4:0] shamt;
    logic       cmp;

    assign shamt = b_i[4:0];

    // comparisons share one result bit
    always_comb begin
        case (op_i)
            EQ:      cmp = (a_i == b_i);
            NE:      cmp = (a_i != b_i);
            LTU:     cmp = (a_i < b_i);
            GEU:     cmp = (a_i >= b_i);
            default: cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            XOR:     result_o = a_i ^ b_i;
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            SLL:     result_o = a_i << shamt;
            SRL:     result_o = a_i >> shamt;
            PASS_B:  result_o = b_i;
            default: result_o = {{(XLEN-1){1'b0}}, cmp};
        endcase
    end

    assign branch_taken_o = cmp;

endmodule

//--- core/rv_decoder.sv
/*
 * Instruction decoder
 * splits an instruction into register fields, builds the immediate
 * and picks the ALU operation and operand source
 */
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    output opcode_e               opcode_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o,
    output alu_op_e               alu_op_o,
    output logic                  use_imm_o
);

    logic [2:0] funct3;
    logic       funct7_b5;

    assign opcode_o  = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];

    always_comb begin
        imm_o     = {{20{instr_i[31]}}, instr_i[31:20]};
        alu_op_o  = ADD;
        use_imm_o = 1'b1;
        rd_o      = instr_i[11:7];
        case (opcode_o)
            OP, OP_IMM: begin
                use_imm_o = (opcode_o == OP_IMM);
                case (funct3)
                    F3_ADD:  alu_op_o = (opcode_o == OP && funct7_b5) ? SUB : ADD;
                    F3_SLL:  alu_op_o = SLL;
                    F3_XOR:  alu_op_o = XOR;
                    F3_SRL:  alu_op_o = SRL;
                    F3_OR:   alu_op_o = OR;
                    F3_AND:  alu_op_o = AND;
                    // unsupported funct3 turns into a write to x0
                    default: rd_o = '0;
                endcase
            end
            STORE: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            BRANCH: begin
                use_imm_o = 1'b0;
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
                case (funct3)
                    F3_BEQ:  alu_op_o = EQ;
                    F3_BNE:  alu_op_o = NE;
                    F3_BLT:  alu_op_o = LTU;
                    F3_BGE:  alu_op_o = GEU;
                    // ADD never reports taken
                    default: alu_op_o = ADD;
                endcase
            end
            JAL: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                          instr_i[20], instr_i[30:21], 1'b0};
            LUI: begin
                imm_o    = {instr_i[31:12], 12'b0};
                alu_op_o = PASS_B;
            end
            // LOAD and JALR keep the I immediate and ADD
            default: ;
        endcase
    end

endmodule

//--- core/rv_regfile.sv
/*
 * Register file, 32 x 32
 * two combinational read ports, one write port, x0 reads zero
 */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            // x0 is never written so it stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

//--- core/rv_sequencer.sv
/*
 * Instruction sequencer
 * multicycle FSM with PC and instruction register, issues fetch and
 * data requests, picks the next PC and the write-back value
 */
`timescale 1ns/1ps

module rv_sequencer import rv_pkg::*, bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                done_i,
    input  logic [WB_DAT_W-1:0] rdata_i,
    input  opcode_e             opcode_i,
    input  logic [XLEN-1:0]     imm_i,
    input  logic [XLEN-1:0]     rs1_data_i,
    input  logic [XLEN-1:0]     rs2_data_i,
    input  logic [XLEN-1:0]     alu_result_i,
    input  logic                branch_taken_i,
    output logic [XLEN-1:0]     instr_o,
    output logic [XLEN-1:0]     pc_o,
    output logic                req_o,
    output logic                req_we_o,
    output logic [WB_ADR_W-1:0] req_adr_o,
    output logic [WB_DAT_W-1:0] req_wdat_o,
    output logic                rd_we_o,
    output logic [XLEN-1:0]     rd_wdata_o
);

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT
    } seq_state_e;

    seq_state_e      state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            is_mem;
    logic            writes_rd;

    assign pc_plus4 = pc + 32'd4;
    assign is_mem   = (opcode_i == LOAD) || (opcode_i == STORE);

    assign writes_rd = (opcode_i == OP) || (opcode_i == OP_IMM) || (opcode_i == LUI)
                    || (opcode_i == JAL) || (opcode_i == JALR);

    // target of the instruction in EXECUTE
    always_comb begin
        case (opcode_i)
            JAL:     next_pc = pc + imm_i;
            JALR:    next_pc = (rs1_data_i + imm_i) & ~32'd1;
            BRANCH:  next_pc = branch_taken_i ? pc + imm_i : pc_plus4;
            default: next_pc = pc_plus4;
        endcase
    end

    // write-back source
    always_comb begin
        case (opcode_i)
            JAL, JALR: rd_wdata_o = pc_plus4;
            LOAD:      rd_wdata_o = rdata_i;
            default:   rd_wdata_o = alu_result_i;
        endcase
    end

    // LW writes when its data returns, the rest in EXECUTE
    assign rd_we_o = (state == EXECUTE && writes_rd)
                  || (state == MEM_WAIT && done_i && opcode_i == LOAD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FETCH;
            pc       <= RESET_PC;
            req_o    <= 1'b0;
            req_we_o <= 1'b0;
        end else begin
            req_o <= 1'b0;
            case (state)
                FETCH: begin
                    req_o    <= 1'b1;
                    req_we_o <= 1'b0;
                    state    <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (done_i) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_mem) begin
                        state <= MEM;
                    end else begin
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end
                MEM: begin
                    req_o    <= 1'b1;
                    req_we_o <= (opcode_i == STORE);
                    state    <= MEM_WAIT;
                end
                MEM_WAIT: begin
                    if (done_i) begin
                        pc    <= pc_plus4;
                        state <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // instruction and request payload
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && done_i) begin
            ir <= rdata_i;
        end
        if (state == FETCH) begin
            req_adr_o <= pc;
        end else if (state == MEM) begin
            req_adr_o  <= alu_result_i;
            req_wdat_o <= rs2_data_i;
        end
    end

    assign instr_o = ir;
    assign pc_o    = pc;

endmodule

//--- src/rv_wb_cpu.sv
/*
 * RV32I subset multicycle CPU with a Wishbone master port
 * connects sequencer, decoder, ALU, register file and bus master
 */
`timescale 1ns/1ps

module rv_wb_cpu import rv_pkg::*, bus_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack_i,
    output logic [XLEN-1:0] wb_adr_o,
    output logic [XLEN-1:0] wb_dat_o,
    output logic            wb_we_o,
    output logic            wb_stb_o,
    output logic            wb_cyc_o
);

    logic [XLEN-1:0]       instr;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic [XLEN-1:0]       alu_b, alu_result;
    logic                  branch_taken;
    logic                  rd_we;
    logic [XLEN-1:0]       rd_wdata;

    // core side of the bus master
    logic                  req, req_we, done;
    logic [WB_ADR_W-1:0]   req_adr;
    logic [WB_DAT_W-1:0]   req_wdat, rdata;

    // second ALU operand
    assign alu_b = use_imm ? imm : rs2_data;

    rv_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .done_i         (done),
        .rdata_i        (rdata),
        .opcode_i       (opcode),
        .imm_i          (imm),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .alu_result_i   (alu_result),
        .branch_taken_i (branch_taken),
        .instr_o        (instr),
        .pc_o           (),
        .req_o          (req),
        .req_we_o       (req_we),
        .req_adr_o      (req_adr),
        .req_wdat_o     (req_wdat),
        .rd_we_o        (rd_we),
        .rd_wdata_o     (rd_wdata)
    );

    rv_decoder u_dec (
        .instr_i   (instr),
        .opcode_o  (opcode),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_o     (imm),
        .alu_op_o  (alu_op),
        .use_imm_o (use_imm)
    );

    rv_alu u_alu (
        .op_i           (alu_op),
        .a_i            (rs1_data),
        .b_i            (alu_b),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    rv_regfile u_rf (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .we_i       (rd_we),
        .wdata_i    (rd_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    wb_master u_wb (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req),
        .req_we_i   (req_we),
        .req_adr_i  (req_adr),
        .req_wdat_i (req_wdat),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_we_o    (wb_we_o),
        .wb_stb_o   (wb_stb_o),
        .wb_cyc_o   (wb_cyc_o),
        .done_o     (done),
        .rdata_o    (rdata)
    );

endmodule

//--- testbench/rv_wb_cpu_chk.sv
/*
 * Bus protocol checker for rv_wb_cpu
 * concurrent assertions on the Wishbone port, bound into the top level
 */
`timescale 1ns/1ps

module rv_wb_cpu_chk import rv_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            wb_ack_i,
    input logic [XLEN-1:0] wb_adr_o,
    input logic [XLEN-1:0] wb_dat_o,
    input logic            wb_we_o,
    input logic            wb_stb_o,
    input logic            wb_cyc_o
);

    // skipped stores in the test program aim here
    localparam logic [XLEN-1:0] POISON_ADR = 32'h3300_1100;

    int   fail_count = 0;
    logic first_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            first_seen <= 1'b0;
        end else if (wb_cyc_o) begin
            first_seen <= 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        rst |-> (!wb_cyc_o && !wb_stb_o && !wb_we_o))
        else begin fail_count++; $error("bus active during reset"); end

    a_first_fetch: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc_o && !first_seen) |-> (!wb_we_o && wb_adr_o == RESET_PC))
        else begin fail_count++; $error("first bus cycle is not a fetch of the reset PC"); end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb_o == wb_cyc_o)
        else begin fail_count++; $error("stb and cyc differ"); end

    // request must hold steady while the slave stalls
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)
                                     && $stable(wb_dat_o) && $stable(wb_we_o)))
        else begin fail_count++; $error("bus request changed before ack"); end

    a_stb_fall: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && wb_ack_i) |=> !wb_stb_o)
        else begin fail_count++; $error("stb still high after ack"); end

    a_no_poison: assert property (@(posedge clk) disable iff (rst)
        !(wb_stb_o && wb_we_o && wb_adr_o == POISON_ADR))
        else begin fail_count++; $error("store to the poison address"); end

endmodule

bind rv_wb_cpu rv_wb_cpu_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .wb_ack_i (wb_ack_i),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_we_o  (wb_we_o),
    .wb_stb_o (wb_stb_o),
    .wb_cyc_o (wb_cyc_o)
);

//--- testbench/tb_rv_wb_cpu.sv
/*
 * Testbench for rv_wb_cpu
 * Wishbone memory model with random ack delay, a fixed test program
 * and per-test checks of the stored signature words
 */
`timescale 1ns/1ps

module tb_rv_wb_cpu import rv_pkg::*, bus_pkg::*; ();

    localparam logic [31:0] DATA_BASE = 32'h3300_1000;
    localparam int          N_INSTR   = 47;
    localparam int          N_TESTS   = 4;
    localparam int          LIMIT     = N_INSTR * 12;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_o;
    logic        wb_we_o;
    logic        wb_stb_o;
    logic        wb_cyc_o;

    logic [31:0] prog [64];
    logic [31:0] dmem [128];
    logic [31:0] exp_val [16];
    bit          word_seen [16];
    int          last_idx [N_TESTS];
    string       test_name [N_TESTS];
    logic [31:0] seed = 32'h760b;
    int          cur_test = 0;
    int          test_errs = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          cycles = 0;
    logic        busy = 1'b0;
    int          wait_cnt = 0;

    rv_wb_cpu u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_we_o  (wb_we_o),
        .wb_stb_o (wb_stb_o),
        .wb_cyc_o (wb_cyc_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic load_program();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 64; i++) begin
            prog[i] = ~(RESET_PC + 32'(i * 4));
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i] = ~(DATA_BASE + 32'(i * 4));
        end
        a = 32'h123;
        b = 32'h5a5;
        // x10 holds the signature base, x1 and x2 the operands
        prog[0]  = u_type(20'h33001, 5'd10);
        prog[1]  = s_type(12'd0, 5'd10, 5'd10);
        prog[2]  = i_type(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[3]  = i_type(12'h5a5, 5'd0, 3'b000, 5'd2, 7'b0010011);
        prog[4]  = s_type(12'd4, 5'd1, 5'd10);
        prog[5]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[6]  = s_type(12'd8, 5'd3, 5'd10);
        prog[7]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
        prog[8]  = s_type(12'd12, 5'd4, 5'd10);
        prog[9]  = r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5);
        prog[10] = s_type(12'd16, 5'd5, 5'd10);
        prog[11] = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
        prog[12] = s_type(12'd20, 5'd6, 5'd10);
        prog[13] = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7);
        prog[14] = s_type(12'd24, 5'd7, 5'd10);
        prog[15] = i_type(12'd4, 5'd0, 3'b000, 5'd8, 7'b0010011);
        prog[16] = r_type(7'h00, 5'd8, 5'd1, 3'b001, 5'd9);
        prog[17] = s_type(12'd28, 5'd9, 5'd10);
        prog[18] = r_type(7'h00, 5'd8, 5'd2, 3'b101, 5'd11);
        prog[19] = s_type(12'd32, 5'd11, 5'd10);
        prog[20] = i_type(12'd8, 5'd10, 3'b010, 5'd12, 7'b0000011);
        prog[21] = s_type(12'd36, 5'd12, 5'd10);
        prog[22] = i_type(12'h7ff, 5'd0, 3'b000, 5'd0, 7'b0010011);
        prog[23] = s_type(12'd40, 5'd0, 5'd10);
        // taken branches each skip a poison store
        prog[24] = b_type(13'd8, 5'd1, 5'd1, 3'b000);
        prog[25] = s_type(12'h100, 5'd1, 5'd10);
        prog[26] = b_type(13'd8, 5'd2, 5'd1, 3'b001);
        prog[27] = s_type(12'h100, 5'd1, 5'd10);
        prog[28] = b_type(13'd8, 5'd2, 5'd1, 3'b100);
        prog[29] = s_type(12'h100, 5'd1, 5'd10);
        prog[30] = b_type(13'd8, 5'd1, 5'd2, 3'b101);
        prog[31] = s_type(12'h100, 5'd1, 5'd10);
        // not taken
        prog[32] = b_type(13'd8, 5'd2, 5'd1, 3'b000);
        prog[33] = s_type(12'd44, 5'd1, 5'd10);
        prog[34] = b_type(13'd8, 5'd2, 5'd1, 3'b101);
        prog[35] = s_type(12'd48, 5'd2, 5'd10);
        prog[36] = b_type(13'd8, 5'd1, 5'd2, 3'b100);
        prog[37] = s_type(12'd52, 5'd3, 5'd10);
        prog[38] = j_type(21'd8, 5'd13);
        prog[39] = s_type(12'h100, 5'd1, 5'd10);
        prog[40] = s_type(12'd56, 5'd13, 5'd10);
        prog[41] = u_type(20'h33000, 5'd15);
        prog[42] = i_type(12'd180, 5'd15, 3'b000, 5'd16, 7'b1100111);
        prog[43] = s_type(12'h100, 5'd1, 5'd10);
        prog[44] = s_type(12'h100, 5'd1, 5'd10);
        prog[45] = s_type(12'd60, 5'd16, 5'd10);
        prog[46] = j_type(21'd0, 5'd0);

        exp_val[0]  = DATA_BASE;
        exp_val[1]  = a;
        exp_val[2]  = a + b;
        exp_val[3]  = a - b;
        exp_val[4]  = a ^ b;
        exp_val[5]  = a | b;
        exp_val[6]  = a & b;
        exp_val[7]  = a << 4;
        exp_val[8]  = b >> 4;
        exp_val[9]  = a + b;
        exp_val[10] = 32'd0;
        exp_val[11] = a;
        exp_val[12] = b;
        exp_val[13] = a + b;
        exp_val[14] = RESET_PC + 32'd39 * 4;
        exp_val[15] = RESET_PC + 32'd43 * 4;

        test_name[0] = "alu_lui";
        test_name[1] = "load_store";
        test_name[2] = "branch";
        test_name[3] = "jump";
        last_idx[0] = 8;
        last_idx[1] = 10;
        last_idx[2] = 13;
        last_idx[3] = 15;
    endtask

    task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
        int idx;
        int first;
        idx = int'((adr - DATA_BASE) >> 2);
        if (adr < DATA_BASE || idx > 15) begin
            $display("store to unexpected address %h at %0t", adr, $time);
            test_errs++;
            return;
        end
        assert (dat == exp_val[idx])
        else begin
            $display("[ERROR] %0t store word %0d: got %h, expected %h",
                     $time, idx, dat, exp_val[idx]);
            test_errs++;
        end
        word_seen[idx] = 1'b1;
        if (cur_test < N_TESTS && idx == last_idx[cur_test]) begin
            first = (cur_test == 0) ? 0 : last_idx[cur_test - 1] + 1;
            // every signature word of the test has to arrive
            for (int k = first; k < idx; k++) begin
                assert (word_seen[k])
                else begin
                    $display("test %s: store word %0d never arrived",
                             test_name[cur_test], k);
                    test_errs++;
                end
            end
            if (test_errs == 0) begin
                $display("test %s: pass", test_name[cur_test]);
                passed++;
            end else begin
                $display("test %s: FAIL (%0d errors)", test_name[cur_test], test_errs);
                failed++;
            end
            errors += test_errs;
            test_errs = 0;
            cur_test++;
        end
    endtask

    // memory slave that answers 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    seed = lcg_next(seed);
                    wait_cnt = int'(seed[17:16]);
                end
                if (wait_cnt == 0) begin
                    busy = 1'b0;
                    wb_ack_i = 1'b1;
                    if (wb_we_o) begin
                        if (wb_adr_o >= DATA_BASE && wb_adr_o < DATA_BASE + 512) begin
                            dmem[(wb_adr_o - DATA_BASE) >> 2] = wb_dat_o;
                        end
                        check_store(wb_adr_o, wb_dat_o);
                    end else if (wb_adr_o >= RESET_PC && wb_adr_o < RESET_PC + 256) begin
                        wb_dat_i = prog[(wb_adr_o - RESET_PC) >> 2];
                    end else if (wb_adr_o >= DATA_BASE && wb_adr_o < DATA_BASE + 512) begin
                        wb_dat_i = dmem[(wb_adr_o - DATA_BASE) >> 2];
                    end else begin
                        wb_dat_i = '0;
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: program did not finish within %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        load_program();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        wait (cur_test == N_TESTS);
        repeat (2) @(posedge clk);
        errors += u_dut.u_chk.fail_count;
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 passed, failed, u_dut.u_chk.fail_count);
        if (errors == 0 && failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
